// ==== dcache_cfg_pkg.sv ====
package dcache_cfg_pkg;

  // cpu address and data width, one word
  localparam int ADDR_W = 32;

  // 64 byte lines
  localparam int OFFSET_W = 6;

  // 32-bit words per line
  localparam int WORDS_PER_LINE = 16;

  // default line count is 2**6 = 64 lines, 4 KiB total
  localparam int DEF_INDEX_W = 6;

  // tag width follows from the default index width
  localparam int TAG_W = ADDR_W - OFFSET_W - DEF_INDEX_W;

  // one tag array entry
  // valid clears on the reset sweep
  // dirty set by write hits, cleared on refill
  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

endpackage

// ==== dcache_bus_pkg.sv ====
package dcache_bus_pkg;

  // access size codes on size_i in bytes
  localparam logic [3:0] SIZE_BYTE = 4'd1;
  localparam logic [3:0] SIZE_HALF = 4'd2;
  localparam logic [3:0] SIZE_WORD = 4'd4;

  // len field is beats minus one
  // full line is 16 beats
  localparam logic [7:0] BURST_LEN = 8'd15;

  // uncached access is a single beat
  localparam logic [7:0] SINGLE_LEN = 8'd0;

  // uncached region
  // address is uncached when (addr & mask) == base
  // default region is everything with bit 31 set
  localparam logic [dcache_cfg_pkg::ADDR_W-1:0] UNCACHE_BASE = 32'h8000_0000;
  localparam logic [dcache_cfg_pkg::ADDR_W-1:0] UNCACHE_MASK = 32'h8000_0000;

endpackage

// ==== dcache_array_if.sv ====
// one port of a storage array
// read data is combinational on addr
interface dcache_array_if #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH_W = 6
);

  logic [DEPTH_W-1:0] addr;
  logic               wen;
  entry_t             wdata;
  entry_t             rdata;

  // controller side
  modport ctrl (
    output addr,
    output wen,
    output wdata,
    input  rdata
  );

  // array side
  modport array (
    input  addr,
    input  wen,
    input  wdata,
    output rdata
  );

endinterface

// ==== dcache_array.sv ====
// single port storage array
// async read, write at clock edge
// serves both tag and data storage
module dcache_array #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH_W = 6
) (
  input logic            clk,
  dcache_array_if.array  port
);

  localparam int DEPTH = 1 << DEPTH_W;

  // entry storage
  entry_t mem [DEPTH];

  // read through
  assign port.rdata = mem[port.addr];

  always_ff @(posedge clk) begin
    if (port.wen) begin
      mem[port.addr] <= port.wdata;
    end
  end

endmodule

// ==== dcache_lane.sv ====
// byte lane helpers
// lane mask for uncached writes
// byte merge for write hits
// sub-word extract for uncached reads
module dcache_lane (
  input  logic [1:0]  addr_lo_i,
  input  logic [3:0]  size_i,
  input  logic [3:0]  cpu_mask_i,
  input  logic [31:0] wdata_i,
  input  logic [31:0] old_word_i,
  input  logic [31:0] mem_word_i,
  output logic [3:0]  lane_mask_o,
  output logic [31:0] merged_o,
  output logic [31:0] extract_o
);

  // byte enables from size and offset
  // unknown size codes fall back to full word
  always_comb begin
    case (size_i)
      dcache_bus_pkg::SIZE_BYTE: lane_mask_o = 4'b0001 << addr_lo_i;
      dcache_bus_pkg::SIZE_HALF: lane_mask_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      default:                   lane_mask_o = 4'b1111;
    endcase
  end

  // new bytes where the cpu mask is set, old bytes elsewhere
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged_o[b*8 +: 8] = cpu_mask_i[b] ? wdata_i[b*8 +: 8] : old_word_i[b*8 +: 8];
    end
  end

  // zero extended, picked by offset
  always_comb begin
    case (size_i)
      dcache_bus_pkg::SIZE_BYTE: extract_o = {24'b0, mem_word_i[addr_lo_i*8 +: 8]};
      dcache_bus_pkg::SIZE_HALF: extract_o = {16'b0, mem_word_i[addr_lo_i[1]*16 +: 16]};
      default:                   extract_o = mem_word_i;
    endcase
  end

endmodule

// ==== dcache_ctrl.sv ====
// cache FSM
// owns the memory port registers and the beat counter
module dcache_ctrl #(
  parameter int INDEX_W = dcache_cfg_pkg::DEF_INDEX_W
) (
  input  logic        clk,
  input  logic        rst,
  // cpu request held until a ready pulse
  input  logic        addr_valid_i,
  input  logic        write_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  mask_i,
  input  logic [3:0]  size_i,
  output logic [31:0] rdata_o,
  output logic        rdata_ready_o,
  output logic        wdata_ready_o,
  // memory read side
  output logic [31:0] raddr_o,
  output logic        rvalid_o,
  output logic [7:0]  rlen_o,
  input  logic        rready_i,
  input  logic [31:0] rdata_i,
  // memory write side
  output logic [31:0] waddr_o,
  output logic        wvalid_o,
  output logic [3:0]  wmask_o,
  output logic [7:0]  wlen_o,
  output logic [31:0] mem_wdata_o,
  input  logic        wready_i,
  // storage arrays
  dcache_array_if.ctrl tag_port,
  dcache_array_if.ctrl data_port,
  // lane logic
  input  logic [3:0]  lane_mask_i,
  input  logic [31:0] merged_i,
  input  logic [31:0] extract_i,
  output logic [1:0]  addr_lo_o,
  output logic [3:0]  size_o,
  output logic [3:0]  cpu_mask_o,
  output logic [31:0] wdata_o,
  output logic [31:0] mem_word_o
);

  localparam int ADDR_W   = dcache_cfg_pkg::ADDR_W;
  localparam int OFFSET_W = dcache_cfg_pkg::OFFSET_W;
  localparam int TAG_W    = dcache_cfg_pkg::TAG_W;
  localparam int WSEL_W   = $clog2(dcache_cfg_pkg::WORDS_PER_LINE);
  localparam logic [WSEL_W-1:0] LAST_BEAT = dcache_bus_pkg::BURST_LEN[WSEL_W-1:0];

  typedef enum logic [2:0] {
    S_CLEAR,
    S_IDLE,
    S_WBACK,
    S_REFILL,
    S_UNC_RD,
    S_UNC_WR
  } state_t;

  state_t                     state;
  logic [WSEL_W-1:0]          beat;
  logic [INDEX_W-1:0]         clr_idx;
  // uncached read word and write data
  logic [31:0]                word_q;
  logic [31:0]                wdata_q;

  logic [TAG_W-1:0]           req_tag;
  logic [INDEX_W-1:0]         req_idx;
  logic [WSEL_W-1:0]          req_word;
  logic                       is_unc;
  logic                       req_ok;
  logic                       hit;
  logic                       write_hit;
  logic                       refill_beat;
  logic                       refill_last;
  logic                       r_hs;
  logic                       w_hs;
  dcache_cfg_pkg::tag_entry_t tag_rd;
  dcache_cfg_pkg::tag_entry_t tag_wr;

  // address split
  assign req_tag  = addr_i[ADDR_W-1 -: TAG_W];
  assign req_idx  = addr_i[OFFSET_W +: INDEX_W];
  assign req_word = addr_i[2 +: WSEL_W];

  // the one place that decides uncached
  assign is_unc = (addr_i & dcache_bus_pkg::UNCACHE_MASK) == dcache_bus_pkg::UNCACHE_BASE;

  // request is not looked at during its own ready pulse
  assign req_ok = addr_valid_i & ~rdata_ready_o & ~wdata_ready_o;

  assign tag_rd = tag_port.rdata;
  assign hit    = tag_rd.valid && (tag_rd.tag == req_tag);

  assign r_hs = rvalid_o & rready_i;
  assign w_hs = wvalid_o & wready_i;

  assign write_hit   = (state == S_IDLE) && req_ok && !is_unc && hit && write_i;
  assign refill_beat = (state == S_REFILL) && r_hs;
  assign refill_last = refill_beat && (beat == LAST_BEAT);

  // tag port
  // sweep index during clear and request index otherwise
  always_comb begin
    tag_wr.valid = (state != S_CLEAR);
    tag_wr.dirty = write_hit;
    tag_wr.tag   = (state == S_CLEAR) ? '0 : req_tag;
    tag_port.addr  = (state == S_CLEAR) ? clr_idx : req_idx;
    tag_port.wen   = (state == S_CLEAR) || write_hit || refill_last;
    tag_port.wdata = tag_wr;
  end

  // data port
  // bursts walk the line by beat and cpu accesses use the word offset
  always_comb begin
    if (state == S_WBACK || state == S_REFILL) begin
      data_port.addr = {req_idx, beat};
    end else begin
      data_port.addr = {req_idx, req_word};
    end
    data_port.wen   = write_hit || refill_beat;
    data_port.wdata = (state == S_REFILL) ? rdata_i : merged_i;
  end

  // write back streams straight from the array
  assign mem_wdata_o = (state == S_WBACK) ? data_port.rdata : wdata_q;

  // cached reads return the array word
  assign rdata_o = is_unc ? extract_i : data_port.rdata;

  // lane logic hookup
  assign addr_lo_o  = addr_i[1:0];
  assign size_o     = size_i;
  assign cpu_mask_o = mask_i;
  assign wdata_o    = wdata_i;
  assign mem_word_o = word_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= S_CLEAR;
      beat          <= '0;
      clr_idx       <= '0;
      rvalid_o      <= 1'b0;
      wvalid_o      <= 1'b0;
      rdata_ready_o <= 1'b0;
      wdata_ready_o <= 1'b0;
    end else begin
      // ready is a one cycle pulse
      rdata_ready_o <= 1'b0;
      wdata_ready_o <= 1'b0;
      case (state)
        S_CLEAR: begin
          // one tag entry per cycle
          clr_idx <= clr_idx + 1'b1;
          if (&clr_idx) begin
            state <= S_IDLE;
          end
        end
        S_IDLE: begin
          if (req_ok) begin
            if (is_unc && write_i) begin
              waddr_o  <= addr_i;
              wvalid_o <= 1'b1;
              wlen_o   <= dcache_bus_pkg::SINGLE_LEN;
              wmask_o  <= lane_mask_i;
              wdata_q  <= wdata_i;
              state    <= S_UNC_WR;
            end else if (is_unc) begin
              raddr_o  <= addr_i;
              rvalid_o <= 1'b1;
              rlen_o   <= dcache_bus_pkg::SINGLE_LEN;
              state    <= S_UNC_RD;
            end else if (hit) begin
              // write hit lands in the arrays this cycle
              wdata_ready_o <= write_i;
              rdata_ready_o <= !write_i;
            end else if (tag_rd.valid && tag_rd.dirty) begin
              // evict the old line first
              waddr_o  <= {tag_rd.tag, req_idx, {OFFSET_W{1'b0}}};
              wvalid_o <= 1'b1;
              wlen_o   <= dcache_bus_pkg::BURST_LEN;
              wmask_o  <= 4'b1111;
              beat     <= '0;
              state    <= S_WBACK;
            end else begin
              raddr_o  <= {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
              rvalid_o <= 1'b1;
              rlen_o   <= dcache_bus_pkg::BURST_LEN;
              beat     <= '0;
              state    <= S_REFILL;
            end
          end
        end
        S_WBACK: begin
          if (w_hs) begin
            beat <= beat + 1'b1;
            if (beat == LAST_BEAT) begin
              // straight into the refill of the new line
              wvalid_o <= 1'b0;
              raddr_o  <= {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
              rvalid_o <= 1'b1;
              rlen_o   <= dcache_bus_pkg::BURST_LEN;
              state    <= S_REFILL;
            end
          end
        end
        S_REFILL: begin
          if (r_hs) begin
            beat <= beat + 1'b1;
            // back to idle where the request then hits
            if (beat == LAST_BEAT) begin
              rvalid_o <= 1'b0;
              state    <= S_IDLE;
            end
          end
        end
        S_UNC_RD: begin
          if (r_hs) begin
            rvalid_o      <= 1'b0;
            word_q        <= rdata_i;
            rdata_ready_o <= 1'b1;
            state         <= S_IDLE;
          end
        end
        S_UNC_WR: begin
          if (w_hs) begin
            wvalid_o      <= 1'b0;
            wdata_ready_o <= 1'b1;
            state         <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== dcache_top.sv ====
// direct mapped write back data cache
// cpu load/store port in, 32-bit burst memory port out
module dcache_top #(
  parameter int INDEX_W = dcache_cfg_pkg::DEF_INDEX_W
) (
  input  logic        clk,
  input  logic        rst,
  // cpu side
  input  logic        addr_valid_i,
  input  logic        write_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  mask_i,
  input  logic [3:0]  size_i,
  output logic [31:0] rdata_o,
  output logic        rdata_ready_o,
  output logic        wdata_ready_o,
  // memory read side
  output logic [31:0] raddr_o,
  output logic        rvalid_o,
  output logic [7:0]  rlen_o,
  input  logic        rready_i,
  input  logic [31:0] rdata_i,
  // memory write side
  output logic [31:0] waddr_o,
  output logic        wvalid_o,
  output logic [3:0]  wmask_o,
  output logic [7:0]  wlen_o,
  output logic [31:0] wdata_o,
  input  logic        wready_i
);

  // data array holds every word of every line
  localparam int DATA_DEPTH_W = INDEX_W + $clog2(dcache_cfg_pkg::WORDS_PER_LINE);

  logic [3:0]  lane_mask;
  logic [31:0] merged;
  logic [31:0] extract;
  logic [1:0]  addr_lo;
  logic [3:0]  lane_size;
  logic [3:0]  cpu_mask;
  logic [31:0] lane_wdata;
  logic [31:0] mem_word;

  dcache_array_if #(
    .entry_t (dcache_cfg_pkg::tag_entry_t),
    .DEPTH_W (INDEX_W)
  ) tag_port ();

  dcache_array_if #(
    .entry_t (logic [dcache_cfg_pkg::ADDR_W-1:0]),
    .DEPTH_W (DATA_DEPTH_W)
  ) data_port ();

  dcache_ctrl #(
    .INDEX_W (INDEX_W)
  ) u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .addr_valid_i  (addr_valid_i),
    .write_i       (write_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .mask_i        (mask_i),
    .size_i        (size_i),
    .rdata_o       (rdata_o),
    .rdata_ready_o (rdata_ready_o),
    .wdata_ready_o (wdata_ready_o),
    .raddr_o       (raddr_o),
    .rvalid_o      (rvalid_o),
    .rlen_o        (rlen_o),
    .rready_i      (rready_i),
    .rdata_i       (rdata_i),
    .waddr_o       (waddr_o),
    .wvalid_o      (wvalid_o),
    .wmask_o       (wmask_o),
    .wlen_o        (wlen_o),
    .mem_wdata_o   (wdata_o),
    .wready_i      (wready_i),
    .tag_port      (tag_port.ctrl),
    .data_port     (data_port.ctrl),
    .lane_mask_i   (lane_mask),
    .merged_i      (merged),
    .extract_i     (extract),
    .addr_lo_o     (addr_lo),
    .size_o        (lane_size),
    .cpu_mask_o    (cpu_mask),
    .wdata_o       (lane_wdata),
    .mem_word_o    (mem_word)
  );

  dcache_lane u_lane (
    .addr_lo_i   (addr_lo),
    .size_i      (lane_size),
    .cpu_mask_i  (cpu_mask),
    .wdata_i     (lane_wdata),
    .old_word_i  (data_port.rdata),
    .mem_word_i  (mem_word),
    .lane_mask_o (lane_mask),
    .merged_o    (merged),
    .extract_o   (extract)
  );

  // tags: one entry per line
  dcache_array #(
    .entry_t (dcache_cfg_pkg::tag_entry_t),
    .DEPTH_W (INDEX_W)
  ) u_tag_array (
    .clk  (clk),
    .port (tag_port.array)
  );

  // data: index and word number
  dcache_array #(
    .entry_t (logic [dcache_cfg_pkg::ADDR_W-1:0]),
    .DEPTH_W (DATA_DEPTH_W)
  ) u_data_array (
    .clk  (clk),
    .port (data_port.array)
  );

endmodule

// ==== dcache_top_sva.sv ====
// protocol checks on the cache controller
module dcache_top_sva (
  input logic        clk,
  input logic        rst,
  input logic        rvalid_o,
  input logic        rready_i,
  input logic [31:0] raddr_o,
  input logic        wvalid_o,
  input logic        wready_i,
  input logic [31:0] waddr_o,
  input logic        rdata_ready_o,
  input logic        wdata_ready_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // count of assertion failures
  int fail_count = 0;

  // read valid and address held until accepted
  assert property (@(posedge clk) disable iff (rst)
    rvalid_o && !rready_i |=> rvalid_o && $stable(raddr_o))
    else begin
      $error("rvalid_o dropped or raddr_o changed before rready_i");
      fail_count++;
    end

  // same for the write side
  assert property (@(posedge clk) disable iff (rst)
    wvalid_o && !wready_i |=> wvalid_o && $stable(waddr_o))
    else begin
      $error("wvalid_o dropped or waddr_o changed before wready_i");
      fail_count++;
    end

  // one completion per cycle at most
  assert property (@(posedge clk) disable iff (rst)
    !(rdata_ready_o && wdata_ready_o))
    else begin
      $error("rdata_ready_o and wdata_ready_o high together");
      fail_count++;
    end

  // memory valids stay low while in reset
  assert property (@(posedge clk) rst |=> !rvalid_o && !wvalid_o)
    else begin
      $error("memory valid high during reset");
      fail_count++;
    end

endmodule

bind dcache_ctrl dcache_top_sva u_sva (
  .clk           (clk),
  .rst           (rst),
  .rvalid_o      (rvalid_o),
  .rready_i      (rready_i),
  .raddr_o       (raddr_o),
  .wvalid_o      (wvalid_o),
  .wready_i      (wready_i),
  .waddr_o       (waddr_o),
  .rdata_ready_o (rdata_ready_o),
  .wdata_ready_o (wdata_ready_o)
);

// ==== tb_dcache_top.sv ====
module tb_dcache_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_REQ = 120;
  localparam int CLEAR_CYC = (1 << dcache_cfg_pkg::DEF_INDEX_W) + 8;

  logic        clk;
  logic        rst;
  logic        addr_valid_i;
  logic        write_i;
  logic [31:0] addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  mask_i;
  logic [3:0]  size_i;
  logic [31:0] rdata_o;
  logic        rdata_ready_o;
  logic        wdata_ready_o;
  logic [31:0] raddr_o;
  logic        rvalid_o;
  logic [7:0]  rlen_o;
  logic        rready_i;
  logic [31:0] rdata_i;
  logic [31:0] waddr_o;
  logic        wvalid_o;
  logic [3:0]  wmask_o;
  logic [7:0]  wlen_o;
  logic [31:0] wdata_o;
  logic        wready_i;

  // separate lfsr states for stimulus and memory model
  logic [31:0] stim_lfsr = 32'h1e0b;
  logic [31:0] mem_lfsr = 32'h1e0b;

  // sparse word memory model
  logic [31:0] mem [int];
  // flat byte reference memory
  logic [7:0]  ref_mem [int];

  int errors = 0;
  int rcnt = 0;
  int wcnt = 0;
  int rbursts = 0;
  int rsingles = 0;
  int wbursts = 0;
  int wsingles = 0;
  int wbeats = 0;
  logic [31:0] last_raddr;
  logic [7:0]  last_rlen;
  logic [31:0] last_waddr;
  logic [7:0]  last_wlen;
  logic [3:0]  last_wmask;
  // word under a single beat write
  logic [31:0] unc_word;

  // line state as seen by the reference over the 4 indices used
  bit          line_valid [4];
  bit          line_dirty [4];
  logic [19:0] line_tag [4];

  dcache_top dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] stim_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic mem_bit();
    mem_lfsr = lfsr_step(mem_lfsr);
    return mem_lfsr[0];
  endfunction

  // untouched memory holds a pattern of the full word address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {~a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    return mem.exists(wa) ? mem[wa] : fill_word(wa);
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    logic [31:0] wa;
    logic [31:0] w;
    wa = {a[31:2], 2'b00};
    w = fill_word(wa);
    for (int b = 0; b < 4; b++) begin
      if (ref_mem.exists(wa + b)) begin
        w[b*8 +: 8] = ref_mem[wa + b];
      end
    end
    return w;
  endfunction

  task automatic ref_store(input logic [31:0] a, input logic [31:0] d, input logic [3:0] m);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) begin
        ref_mem[{a[31:2], 2'b00} + b] = d[b*8 +: 8];
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  // memory side with random ready gaps from one lfsr bit per cycle
  always @(posedge clk) begin
    if (rvalid_o && rready_i) begin
      if (rcnt == 0) begin
        last_raddr = raddr_o;
        last_rlen  = rlen_o;
        if (rlen_o == dcache_bus_pkg::BURST_LEN) rbursts++;
        else rsingles++;
      end
      rcnt++;
    end
    if (!rvalid_o) rcnt = 0;
    rready_i <= rvalid_o && mem_bit();
    rdata_i  <= mem_word(raddr_o + 4 * rcnt);

    if (wvalid_o && wready_i) begin
      if (wcnt == 0) begin
        last_waddr = waddr_o;
        last_wlen  = wlen_o;
        last_wmask = wmask_o;
        if (wlen_o == dcache_bus_pkg::BURST_LEN) wbursts++;
        else wsingles++;
      end
      if (wlen_o == dcache_bus_pkg::BURST_LEN) begin
        // evicted line must match the reference
        compare_value("wdata_o", wdata_o, ref_word(waddr_o + 4 * wcnt));
        mem[waddr_o + 4 * wcnt] = wdata_o;
        wbeats++;
      end else begin
        // bytes outside the mask keep their old value
        unc_word = mem_word(waddr_o);
        for (int b = 0; b < 4; b++) begin
          if (wmask_o[b]) begin
            unc_word[b*8 +: 8] = wdata_o[b*8 +: 8];
          end
        end
        mem[{waddr_o[31:2], 2'b00}] = unc_word;
      end
      wcnt++;
    end
    if (!wvalid_o) wcnt = 0;
    wready_i <= wvalid_o && mem_bit();
  end

  // drive one request and wait for its ready pulse
  task automatic run_request(input bit wr, input logic [31:0] a, input logic [31:0] wd,
                             input logic [3:0] m, input logic [3:0] sz,
                             output logic [31:0] rd, output int cyc, output bit got_w);
    @(posedge clk);
    addr_valid_i <= 1'b1;
    write_i      <= wr;
    addr_i       <= a;
    wdata_i      <= wd;
    mask_i       <= m;
    size_i       <= sz;
    cyc = 0;
    while (1) begin
      @(negedge clk);
      cyc++;
      if (rdata_ready_o || wdata_ready_o) break;
    end
    rd    = rdata_o;
    got_w = wdata_ready_o;
    @(posedge clk);
    addr_valid_i <= 1'b0;
  endtask

  // watchdog
  initial begin
    #(NUM_REQ * 40 * 40 + CLEAR_CYC * 40);
    $display("timeout, requests did not complete");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    bit          wr;
    bit          unc;
    bit          hit;
    bit          got_w;
    int          kind;
    int          idx;
    int          cyc;
    int          err0;
    int          rb0;
    int          rs0;
    int          wb0;
    int          ws0;
    int          beats0;
    int          npass;
    int          sva_fails;
    logic [19:0] tag;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] exp;
    logic [3:0]  m;
    logic [3:0]  sz;
    logic [3:0]  lane;
    string       what;

    clk          = 1'b0;
    rst          = 1'b1;
    addr_valid_i = 1'b0;
    write_i      = 1'b0;
    addr_i       = '0;
    wdata_i      = '0;
    mask_i       = '0;
    size_i       = '0;
    rready_i     = 1'b0;
    rdata_i      = '0;
    wready_i     = 1'b0;
    npass        = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < NUM_REQ; i++) begin
      kind = stim_bits(2);
      unc  = (kind == 3);
      wd   = stim_bits(32);
      if (unc) begin
        wr = stim_bits(1);
        case (stim_bits(2))
          0: begin
            sz = dcache_bus_pkg::SIZE_BYTE;
            a = 32'h8000_0100 | (stim_bits(4) << 2) | stim_bits(2);
            lane = 4'b0001 << a[1:0];
          end
          1: begin
            sz = dcache_bus_pkg::SIZE_HALF;
            a = 32'h8000_0100 | (stim_bits(4) << 2) | (stim_bits(1) << 1);
            lane = a[1] ? 4'b1100 : 4'b0011;
          end
          default: begin
            sz = dcache_bus_pkg::SIZE_WORD;
            a = 32'h8000_0100 | (stim_bits(4) << 2);
            lane = 4'b1111;
          end
        endcase
        m = lane;
      end else begin
        wr  = (kind == 2);
        tag = stim_bits(1) ? 20'h12345 : 20'h00a1c;
        idx = stim_bits(2);
        a   = {tag, 6'(idx), 4'(stim_bits(4)), 2'b00};
        m   = stim_bits(4);
        sz  = dcache_bus_pkg::SIZE_WORD;
      end
      hit    = !unc && line_valid[idx] && line_tag[idx] == tag;
      err0   = errors;
      rb0    = rbursts;
      rs0    = rsingles;
      wb0    = wbursts;
      ws0    = wsingles;
      beats0 = wbeats;
      exp    = ref_word(a);

      run_request(wr, a, wd, m, sz, rd, cyc, got_w);

      expect_true(got_w == wr, "ready pulse on the wrong side");
      if (unc) begin
        what = wr ? "uncached write" : "uncached read";
        expect_true(rbursts == rb0 && wbursts == wb0, "line burst on uncached access");
        if (wr) begin
          expect_true(wsingles == ws0 + 1, "uncached write beat missing");
          compare_value("waddr_o", last_waddr, a);
          compare_value("wmask_o", last_wmask, lane);
          compare_value("wlen_o", last_wlen, dcache_bus_pkg::SINGLE_LEN);
          ref_store(a, wd, lane);
        end else begin
          expect_true(rsingles == rs0 + 1, "uncached read beat missing");
          compare_value("raddr_o", last_raddr, a);
          compare_value("rlen_o", last_rlen, dcache_bus_pkg::SINGLE_LEN);
          if (sz == dcache_bus_pkg::SIZE_BYTE) exp = (exp >> (8 * a[1:0])) & 32'hff;
          else if (sz == dcache_bus_pkg::SIZE_HALF) exp = a[1] ? exp[31:16] : exp[15:0];
          compare_value("rdata_o", rd, exp);
        end
      end else begin
        if (hit) begin
          what = wr ? "write hit" : "read hit";
          expect_true(cyc == 2, "hit ready not one cycle after request");
          expect_true(rbursts == rb0 && wbursts == wb0, "burst on a hit");
        end else begin
          what = line_dirty[idx] && line_valid[idx] ? "dirty miss" : "clean miss";
          expect_true(rbursts == rb0 + 1, "refill burst missing");
          compare_value("raddr_o", last_raddr, {a[31:6], 6'b0});
          compare_value("rlen_o", last_rlen, dcache_bus_pkg::BURST_LEN);
          if (line_valid[idx] && line_dirty[idx]) begin
            expect_true(wbursts == wb0 + 1 && wbeats == beats0 + 16,
                        "write back did not send 16 beats");
            compare_value("waddr_o", last_waddr, {line_tag[idx], 6'(idx), 6'b0});
            compare_value("wlen_o", last_wlen, dcache_bus_pkg::BURST_LEN);
          end else begin
            expect_true(wbursts == wb0, "write back on a clean miss");
          end
          line_valid[idx] = 1'b1;
          line_tag[idx]   = tag;
          line_dirty[idx] = 1'b0;
        end
        if (wr) begin
          ref_store(a, wd, m);
          line_dirty[idx] = 1'b1;
        end else begin
          compare_value("rdata_o", rd, exp);
        end
      end
      if (errors == err0) npass++;
      $display("test %0d %s addr %h %s", i, what, a, (errors == err0) ? "ok" : "bad");
    end

    sva_fails = dut.u_ctrl.u_sva.fail_count;
    $display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
             NUM_REQ, npass, NUM_REQ - npass, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== dcache.f ====
dcache_cfg_pkg.sv
dcache_bus_pkg.sv
dcache_array_if.sv
dcache_array.sv
dcache_lane.sv
dcache_ctrl.sv
dcache_top.sv
dcache_top_sva.sv
tb_dcache_top.sv
